/* src.f */
+incdir+src
src/muldiv_pkg.sv
src/mul_dpath.sv
src/mul_ctrl.sv
src/div_iterative.sv
src/muldiv_dispatch.sv
src/muldiv_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_muldiv.sv

/* src/div_iterative.sv */
// ------------------------------------------------
// signed restoring divider, one quotient bit per cycle
// result is {remainder, quotient}
// ------------------------------------------------
`default_nettype none
`include "muldiv_consts.svh"

module div_iterative
  import muldiv_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  input  logic [`MULDIV_XLEN-1:0]     a,
  input  logic [`MULDIV_XLEN-1:0]     b,
  input  logic                        resp_rdy,
  output logic                        req_rdy,
  output logic                        resp_val,
  output logic [`MULDIV_RESULT_W-1:0] result
);

  div_state_e               state;
  logic [`MULDIV_CNT_W-1:0] cnt_reg;

  // rem holds the partial remainder, quo starts as the dividend
  // and fills with quotient bits from the bottom
  logic [`MULDIV_XLEN-1:0] rem_reg;
  logic [`MULDIV_XLEN-1:0] quo_reg;
  logic [`MULDIV_XLEN-1:0] dvsr_reg;
  logic                    neg_quo;
  logic                    neg_rem;

  logic [`MULDIV_XLEN-1:0] a_mag;
  logic [`MULDIV_XLEN-1:0] b_mag;
  logic [`MULDIV_XLEN:0]   rem_shift;
  logic [`MULDIV_XLEN:0]   rem_diff;
  logic                    rem_ge;
  logic [`MULDIV_XLEN-1:0] rem_out;
  logic [`MULDIV_XLEN-1:0] quo_out;

  assign a_mag = a[`MULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`MULDIV_XLEN-1] ? (~b + 1'b1) : b;

  // ------------------------------------------------
  // one restoring step
  // ------------------------------------------------
  // bring down the next dividend bit, then trial subtract
  assign rem_shift = {rem_reg, quo_reg[`MULDIV_XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, dvsr_reg};
  // no borrow means remainder >= divisor
  assign rem_ge    = ~rem_diff[`MULDIV_XLEN];

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= DIV_IDLE;
      cnt_reg <= '0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (req_val) begin
            state   <= DIV_CALC;
            cnt_reg <= {`MULDIV_CNT_W{1'b1}};
          end
        end
        DIV_CALC: begin
          cnt_reg <= cnt_reg - 1'b1;
          if (cnt_reg == '0) state <= DIV_DONE;
        end
        DIV_DONE: if (resp_rdy) state <= DIV_IDLE;
        default:  state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && req_val) begin
      rem_reg  <= '0;
      quo_reg  <= a_mag;
      dvsr_reg <= b_mag;
      // zero divisor keeps the all-ones quotient unsigned
      neg_quo  <= (a[`MULDIV_XLEN-1] ^ b[`MULDIV_XLEN-1]) && (b != '0);
      neg_rem  <= a[`MULDIV_XLEN-1];
    end else if (state == DIV_CALC) begin
      rem_reg <= rem_ge ? rem_diff[`MULDIV_XLEN-1:0] : rem_shift[`MULDIV_XLEN-1:0];
      quo_reg <= {quo_reg[`MULDIV_XLEN-2:0], rem_ge};
    end
  end

  // sign fix-up, quotient by xor of signs, remainder follows dividend
  assign quo_out = neg_quo ? (~quo_reg + 1'b1) : quo_reg;
  assign rem_out = neg_rem ? (~rem_reg + 1'b1) : rem_reg;

  assign result   = {rem_out, quo_out};
  assign req_rdy  = (state == DIV_IDLE);
  assign resp_val = (state == DIV_DONE);

endmodule

`default_nettype wire

/* src/mul_ctrl.sv */
// ------------------------------------------------
// multiplier control FSM, IDLE -> CALC x32 -> DONE
// sequences mul_dpath and owns the val/rdy handshakes
// ------------------------------------------------
`default_nettype none
`include "muldiv_consts.svh"

module mul_ctrl
  import muldiv_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic cnt_zero,
  input  logic b_lsb,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic result_en,
  output logic result_clr,
  output logic add_en,
  output logic cnt_dec,
  output logic sign_en
);

  mul_state_e state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MUL_IDLE;
    end else begin
      case (state)
        MUL_IDLE: if (req_val) state <= MUL_CALC;
        // counter reads zero during the 32nd step
        MUL_CALC: if (cnt_zero) state <= MUL_DONE;
        MUL_DONE: if (resp_rdy) state <= MUL_IDLE;
        default:  state <= MUL_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // control outputs
  // ------------------------------------------------
  always_comb begin
    req_rdy    = 1'b0;
    resp_val   = 1'b0;
    a_en       = 1'b0;
    a_sel      = 1'b0;
    b_en       = 1'b0;
    b_sel      = 1'b0;
    result_en  = 1'b0;
    result_clr = 1'b0;
    add_en     = 1'b0;
    cnt_dec    = 1'b0;
    sign_en    = 1'b0;
    case (state)
      MUL_IDLE: begin
        req_rdy = 1'b1;
        // load operands, clear accumulator, capture sign, preset counter
        if (req_val) begin
          a_en       = 1'b1;
          b_en       = 1'b1;
          result_en  = 1'b1;
          result_clr = 1'b1;
          sign_en    = 1'b1;
        end
      end
      MUL_CALC: begin
        // one shift/add step per cycle
        a_en      = 1'b1;
        a_sel     = 1'b1;
        b_en      = 1'b1;
        b_sel     = 1'b1;
        result_en = 1'b1;
        add_en    = b_lsb;
        cnt_dec   = 1'b1;
      end
      MUL_DONE: resp_val = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* src/mul_dpath.sv */
// ------------------------------------------------
// multiplier datapath doing shift-and-add on magnitudes
// driven cycle by cycle from mul_ctrl
// ------------------------------------------------
`default_nettype none
`include "muldiv_consts.svh"

module mul_dpath
  import muldiv_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`MULDIV_XLEN-1:0]     a,
  input  logic [`MULDIV_XLEN-1:0]     b,
  input  logic                        a_en,
  input  logic                        a_sel,
  input  logic                        b_en,
  input  logic                        b_sel,
  input  logic                        result_en,
  input  logic                        result_clr,
  input  logic                        add_en,
  input  logic                        cnt_dec,
  input  logic                        sign_en,
  output logic                        cnt_zero,
  output logic                        b_lsb,
  output logic [`MULDIV_RESULT_W-1:0] result
);

  logic [`MULDIV_RESULT_W-1:0] a_reg;
  logic [`MULDIV_XLEN-1:0]     b_reg;
  logic [`MULDIV_RESULT_W-1:0] acc_reg;
  logic [`MULDIV_CNT_W-1:0]    cnt_reg;
  logic                        sign_reg;
  logic [`MULDIV_XLEN-1:0]     a_mag;
  logic [`MULDIV_XLEN-1:0]     b_mag;

  // ------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------
  // most-negative stays 32'h8000_0000 and is still right as unsigned
  assign a_mag = a[`MULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`MULDIV_XLEN-1] ? (~b + 1'b1) : b;

  // a is zero-extended so it can shift up into the high half
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_sel ? (a_reg << 1) : {{`MULDIV_XLEN{1'b0}}, a_mag};
    end
    if (b_en) begin
      b_reg <= b_sel ? (b_reg >> 1) : b_mag;
    end
    // accumulate shifted a when the current multiplier bit is set
    if (result_en) begin
      if (result_clr) begin
        acc_reg <= '0;
      end else if (add_en) begin
        acc_reg <= acc_reg + a_reg;
      end
    end
  end

  // step counter and product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_reg  <= '0;
      sign_reg <= 1'b0;
    end else begin
      if (result_clr) begin
        cnt_reg <= {`MULDIV_CNT_W{1'b1}};
      end else if (cnt_dec) begin
        cnt_reg <= cnt_reg - 1'b1;
      end
      if (sign_en) begin
        sign_reg <= a[`MULDIV_XLEN-1] ^ b[`MULDIV_XLEN-1];
      end
    end
  end

  assign cnt_zero = (cnt_reg == '0);
  assign b_lsb    = b_reg[0];

  // sign fix-up on the way out
  assign result = sign_reg ? (~acc_reg + 1'b1) : acc_reg;

endmodule

`default_nettype wire

/* src/muldiv_consts.svh */
// ------------------------------------------------
// widths shared by the mul/div unit and its testbench
// include once per file that needs them
// ------------------------------------------------
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// operand width
`define MULDIV_XLEN 32

// response width, full product or {rem, quo}
`define MULDIV_RESULT_W 64

// iteration counter, counts down 31..0 for 32 steps
`define MULDIV_CNT_W 5

`endif

/* src/muldiv_dispatch.sv */
// ------------------------------------------------
// steers requests to the multiplier or divider by opcode
// and returns the response of the one outstanding op
// ------------------------------------------------
`default_nettype none
`include "muldiv_consts.svh"

module muldiv_dispatch
  import muldiv_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  input  muldiv_op_e                  req_op,
  input  logic                        mul_req_rdy,
  input  logic                        div_req_rdy,
  input  logic                        mul_resp_val,
  input  logic                        div_resp_val,
  input  logic [`MULDIV_RESULT_W-1:0] mul_result,
  input  logic [`MULDIV_RESULT_W-1:0] div_result,
  input  logic                        resp_rdy,
  output logic                        req_rdy,
  output logic                        mul_req_val,
  output logic                        div_req_val,
  output logic                        mul_resp_rdy,
  output logic                        div_resp_rdy,
  output logic                        resp_val,
  output logic [`MULDIV_RESULT_W-1:0] resp_result
);

  logic       busy;
  muldiv_op_e op_reg;

  // request side, valid never looks at the unit's ready
  assign mul_req_val = req_val && !busy && (req_op == OP_MUL);
  assign div_req_val = req_val && !busy && (req_op == OP_DIV);
  assign req_rdy     = !busy && ((req_op == OP_MUL) ? mul_req_rdy : div_req_rdy);

  // response side, picked by the recorded opcode
  assign resp_val     = busy && ((op_reg == OP_MUL) ? mul_resp_val : div_resp_val);
  assign resp_result  = (op_reg == OP_MUL) ? mul_result : div_result;
  assign mul_resp_rdy = busy && (op_reg == OP_MUL) && resp_rdy;
  assign div_resp_rdy = busy && (op_reg == OP_DIV) && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      op_reg <= OP_MUL;
    end else if (req_val && req_rdy) begin
      busy   <= 1'b1;
      op_reg <= req_op;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/muldiv_pkg.sv */
// ------------------------------------------------
// opcode and FSM state types for the mul/div unit
// ------------------------------------------------
`default_nettype none

package muldiv_pkg;

  // request opcode
  typedef enum logic {
    OP_MUL = 1'b0,
    OP_DIV = 1'b1
  } muldiv_op_e;

  // multiplier control FSM
  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_CALC = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_e;

  // divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

/* src/muldiv_unit.sv */
// ------------------------------------------------
// signed 32-bit iterative mul/div unit, top level
// one val/rdy request port, one val/rdy response port
// ------------------------------------------------
`default_nettype none
`include "muldiv_consts.svh"

module muldiv_unit
  import muldiv_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req_val,
  output logic                        req_rdy,
  input  muldiv_op_e                  req_op,
  input  logic [`MULDIV_XLEN-1:0]     req_a,
  input  logic [`MULDIV_XLEN-1:0]     req_b,
  output logic                        resp_val,
  input  logic                        resp_rdy,
  output logic [`MULDIV_RESULT_W-1:0] resp_result
);

  // dispatch <-> units
  logic                        mul_req_val;
  logic                        mul_req_rdy;
  logic                        mul_resp_val;
  logic                        mul_resp_rdy;
  logic [`MULDIV_RESULT_W-1:0] mul_result;
  logic                        div_req_val;
  logic                        div_req_rdy;
  logic                        div_resp_val;
  logic                        div_resp_rdy;
  logic [`MULDIV_RESULT_W-1:0] div_result;

  // multiplier ctrl -> dpath
  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic result_en;
  logic result_clr;
  logic add_en;
  logic cnt_dec;
  logic sign_en;
  logic cnt_zero;
  logic b_lsb;

  muldiv_dispatch u_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_op       (req_op),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_rdy  (div_req_rdy),
    .mul_resp_val (mul_resp_val),
    .div_resp_val (div_resp_val),
    .mul_result   (mul_result),
    .div_result   (div_result),
    .resp_rdy     (resp_rdy),
    .req_rdy      (req_rdy),
    .mul_req_val  (mul_req_val),
    .div_req_val  (div_req_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy),
    .resp_val     (resp_val),
    .resp_result  (resp_result)
  );

  mul_ctrl u_mul_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_val    (mul_req_val),
    .resp_rdy   (mul_resp_rdy),
    .cnt_zero   (cnt_zero),
    .b_lsb      (b_lsb),
    .req_rdy    (mul_req_rdy),
    .resp_val   (mul_resp_val),
    .a_en       (a_en),
    .a_sel      (a_sel),
    .b_en       (b_en),
    .b_sel      (b_sel),
    .result_en  (result_en),
    .result_clr (result_clr),
    .add_en     (add_en),
    .cnt_dec    (cnt_dec),
    .sign_en    (sign_en)
  );

  mul_dpath u_mul_dpath (
    .clk        (clk),
    .reset      (reset),
    .a          (req_a),
    .b          (req_b),
    .a_en       (a_en),
    .a_sel      (a_sel),
    .b_en       (b_en),
    .b_sel      (b_sel),
    .result_en  (result_en),
    .result_clr (result_clr),
    .add_en     (add_en),
    .cnt_dec    (cnt_dec),
    .sign_en    (sign_en),
    .cnt_zero   (cnt_zero),
    .b_lsb      (b_lsb),
    .result     (mul_result)
  );

  div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .a        (req_a),
    .b        (req_b),
    .resp_rdy (div_resp_rdy),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .result   (div_result)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// ------------------------------------------------
// free-running clock for the mul/div testbench
// ------------------------------------------------
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  // half period low, half period high
  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* testbench/tb_muldiv.sv */
// ------------------------------------------------
// testbench for the mul/div unit, directed and random ops
// responses checked against a reference model, with back-pressure
// ------------------------------------------------
`default_nettype none
`include "muldiv_consts.svh"

module tb_muldiv
  import muldiv_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam logic [31:0] SEED = 32'hcfd7_8de7;
  localparam int N_DIRECTED = 22;
  localparam int N_RANDOM = 200;
  localparam int N_BP = 40;
  localparam int N_OPS = N_DIRECTED + N_RANDOM + N_BP;
  localparam int TIMEOUT_CYCLES = N_OPS * 40 + 200;
  // request transfer edge to first edge that sees resp_val
  localparam int LATENCY = 33;

  logic                        clk;
  logic                        reset;
  logic                        req_val;
  logic                        req_rdy;
  muldiv_op_e                  req_op;
  logic [`MULDIV_XLEN-1:0]     req_a;
  logic [`MULDIV_XLEN-1:0]     req_b;
  logic                        resp_val;
  logic                        resp_rdy;
  logic [`MULDIV_RESULT_W-1:0] resp_result;

  // expected responses in request order, with the operands for messages
  logic [`MULDIV_RESULT_W-1:0] exp_q[$];
  logic [`MULDIV_XLEN-1:0]     a_q[$];
  logic [`MULDIV_XLEN-1:0]     b_q[$];
  muldiv_op_e                  op_q[$];

  logic [31:0]                 rnd_state;
  logic [31:0]                 bp_state;
  logic                        bp_mode;
  logic [1:0]                  bp_left;
  logic                        in_flight;
  logic                        wait_first;
  logic                        held_valid;
  logic [`MULDIV_RESULT_W-1:0] held_result;
  logic [`MULDIV_RESULT_W-1:0] exp_val;
  muldiv_op_e                  exp_op;
  logic [`MULDIV_XLEN-1:0]     exp_a;
  logic [`MULDIV_XLEN-1:0]     exp_b;
  int                          cycle_cnt;
  int                          req_cycle;
  int                          req_count;
  int                          resp_count;
  int                          check_count;
  int                          error_count;

  tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clock_gen (.clk(clk));

  muldiv_unit u_muldiv_unit (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // product, or {remainder, quotient} with the zero and overflow rules
  function automatic logic [`MULDIV_RESULT_W-1:0] expected_result(
    input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] da;
    logic signed [31:0] db;
    logic [31:0]        quo;
    logic [31:0]        rem;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    da = a;
    db = b;
    if (op == OP_MUL) begin
      return sa * sb;
    end
    if (b == 32'd0) begin
      quo = 32'hffff_ffff;
      rem = a;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      quo = 32'h8000_0000;
      rem = 32'd0;
    end else begin
      // truncating division, remainder carries the dividend's sign
      quo = da / db;
      rem = da % db;
    end
    return {rem, quo};
  endfunction

  task automatic send_op(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    @(negedge clk);
    req_val = 1'b1;
    req_op  = op;
    req_a   = a;
    req_b   = b;
    exp_q.push_back(expected_result(op, a, b));
    op_q.push_back(op);
    a_q.push_back(a);
    b_q.push_back(b);
    // hold until the unit takes the request
    do begin
      @(posedge clk);
    end while (!req_rdy);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic run_random(input int count);
    muldiv_op_e  op;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < count; i++) begin
      rnd_state = xorshift32(rnd_state);
      a = rnd_state;
      rnd_state = xorshift32(rnd_state);
      b = rnd_state;
      rnd_state = xorshift32(rnd_state);
      op = rnd_state[5] ? OP_DIV : OP_MUL;
      // shrink b by a random amount so quotients vary in size
      b = $signed(b) >>> rnd_state[4:0];
      send_op(op, a, b);
    end
  endtask

  // ------------------------------------------------
  // response ready, random stretches under back-pressure
  // ------------------------------------------------
  always @(negedge clk) begin
    if (!bp_mode) begin
      resp_rdy = 1'b1;
    end else if (bp_left == 2'd0) begin
      bp_state = xorshift32(bp_state);
      resp_rdy = bp_state[0];
      bp_left  = bp_state[3:2];
    end else begin
      bp_left = bp_left - 1'b1;
    end
  end

  // ------------------------------------------------
  // comparison process, samples handshakes at the rising edge
  // ------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt++;
    if (!reset) begin
      // a stalled response must hold still
      if (held_valid) begin
        check_count++;
        if (!resp_val || resp_result !== held_result) begin
          error_count++;
          $display("** Error at %0t: stalled response changed, expected val=1 %h got val=%b %h",
                   $time, held_result, resp_val, resp_result);
        end
      end
      if (in_flight && req_rdy) begin
        error_count++;
        $display("** Error at %0t: req_rdy high while an operation is outstanding", $time);
      end
      if (resp_val && wait_first) begin
        check_count++;
        wait_first = 1'b0;
        if (cycle_cnt - req_cycle != LATENCY) begin
          error_count++;
          $display("** Error at %0t: resp_val after %0d cycles, expected %0d",
                   $time, cycle_cnt - req_cycle, LATENCY);
        end
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("** Error at %0t: response with no request outstanding", $time);
        end else begin
          exp_val = exp_q.pop_front();
          exp_op  = op_q.pop_front();
          exp_a   = a_q.pop_front();
          exp_b   = b_q.pop_front();
          check_count++;
          if (resp_result !== exp_val) begin
            error_count++;
            $display("** Error at %0t: %s a=%h b=%h expected %h got %h", $time,
                     (exp_op == OP_MUL) ? "mul" : "div", exp_a, exp_b, exp_val, resp_result);
          end
        end
        in_flight = 1'b0;
        resp_count++;
      end
      held_valid  = resp_val && !resp_rdy;
      held_result = resp_result;
      if (req_val && req_rdy) begin
        in_flight  = 1'b1;
        wait_first = 1'b1;
        req_cycle  = cycle_cnt;
        req_count++;
      end
    end
  end

  // ------------------------------------------------
  // watchdog
  // ------------------------------------------------
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d clock periods", TIMEOUT_CYCLES);
    $display("checks: %0d  errors: %0d", check_count, error_count);
    $display("*** FAILED ***");
    $finish;
  end

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    reset       = 1'b1;
    req_val     = 1'b0;
    req_op      = OP_MUL;
    req_a       = '0;
    req_b       = '0;
    resp_rdy    = 1'b1;
    bp_mode     = 1'b0;
    bp_left     = 2'd0;
    rnd_state   = SEED;
    bp_state    = ~SEED;
    in_flight   = 1'b0;
    wait_first  = 1'b0;
    held_valid  = 1'b0;
    held_result = '0;
    cycle_cnt   = 0;
    req_cycle   = 0;
    req_count   = 0;
    resp_count  = 0;
    check_count = 0;
    error_count = 0;
    // four rising edges in reset
    repeat (4) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_count++;
    if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
      error_count++;
      $display("** Error at %0t: after reset req_rdy=%b resp_val=%b, expected 1 and 0",
               $time, req_rdy, resp_val);
    end

    // directed multiplies
    send_op(OP_MUL, 32'd0, 32'd12345);
    send_op(OP_MUL, 32'd1, 32'hffff_ffff);
    send_op(OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
    send_op(OP_MUL, 32'h8000_0000, 32'd1);
    send_op(OP_MUL, 32'h8000_0000, 32'h8000_0000);
    send_op(OP_MUL, 32'h8000_0000, 32'hffff_ffff);
    send_op(OP_MUL, 32'd7, -32'sd3);
    send_op(OP_MUL, -32'sd123456, 32'd654321);
    send_op(OP_MUL, 32'h7fff_ffff, 32'h7fff_ffff);
    send_op(OP_MUL, 32'hffff_ffff, 32'h7fff_ffff);

    // directed divides, all sign combinations and the corner cases
    send_op(OP_DIV, 32'd7, 32'd2);
    send_op(OP_DIV, -32'sd7, 32'd2);
    send_op(OP_DIV, 32'd7, -32'sd2);
    send_op(OP_DIV, -32'sd7, -32'sd2);
    send_op(OP_DIV, 32'd100, 32'd0);
    send_op(OP_DIV, -32'sd100, 32'd0);
    send_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_op(OP_DIV, 32'h8000_0000, 32'd1);
    send_op(OP_DIV, 32'd0, 32'd5);
    send_op(OP_DIV, 32'd5, 32'd7);
    send_op(OP_DIV, 32'h7fff_ffff, 32'hffff_ffff);
    send_op(OP_DIV, 32'h8000_0000, 32'd0);

    run_random(N_RANDOM);

    // same again with the response side stalling
    @(posedge clk);
    bp_mode = 1'b1;
    run_random(N_BP);
    @(posedge clk);
    bp_mode = 1'b0;

    while (in_flight || exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    check_count++;
    if (req_count != N_OPS || resp_count != N_OPS) begin
      error_count++;
      $display("** Error at %0t: %0d requests and %0d responses, expected %0d of each",
               $time, req_count, resp_count, N_OPS);
    end

    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
